// File: list.f
+incdir+source
source/aud_types_pkg.sv
source/aud_ctrl_pkg.sv
source/aud_sample_mem.sv
source/aud_lrck_gen.sv
source/aud_speed_ctrl.sv
source/aud_player.sv
source/aud_playback_top.sv
testbench/aud_playback_checker.sv
testbench/tb_aud_playback.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aud_playback
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f list.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_aud_playback.sv
`timescale 1ns/10ps
`include "aud_config.svh"

module tb_aud_playback;
	import aud_types_pkg::*;
	import aud_ctrl_pkg::*;

	localparam int FRAME = 2 * `AUD_HALF_FRAME;
	localparam int N = 32;

	logic       clk = 1'b0;
	logic       rst_n, start, stop, pause, wr_en;
	play_mode_e mode_in;
	speed_t     speed_in;
	count_t     rec_count;
	addr_t      wr_addr;
	sample_t    wr_data;
	logic       daclrck, dacdat, frame_active, finish;

	sample_t    smem [N];
	sample_t    cap_word;
	int         seed;
	int         cap_bits = 0;
	int         pause_len = 0;
	int         cycle_cnt = 0;
	int         cycle_limit = 1000;
	int         out_idx = 0;
	int         exp_total = 0;
	int         fin_expect = 0;
	int         finish_cnt = 0;
	int         held_idx;
	int         run_speed = 1;
	play_mode_e run_mode = PLAY_FAST;
	logic       prev_active = 1'b0;

	aud_playback_top DUT (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_start        (start),
		.i_stop         (stop),
		.i_pause        (pause),
		.i_mode         (mode_in),
		.i_speed        (speed_in),
		.i_record_count (rec_count),
		.i_wr_en        (wr_en),
		.i_wr_addr      (wr_addr),
		.i_wr_data      (wr_data),
		.o_daclrck      (daclrck),
		.o_dacdat       (dacdat),
		.o_frame_active (frame_active),
		.o_finish       (finish)
	);

	bind aud_playback_top aud_playback_checker u_checker (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_daclrck      (o_daclrck),
		.i_dacdat       (o_dacdat),
		.i_frame_active (o_frame_active),
		.i_finish       (o_finish)
	);

	always #10 clk = ~clk;

	function automatic int ref_count(input play_mode_e mode, input int spd);
		if (mode == PLAY_FAST) return (N + spd - 1) / spd;
		return spd * (N - 1) + 1;
	endfunction

	// expected output k of a run
	function automatic sample_t ref_sample(input play_mode_e mode, input int spd, input int k);
		int j;
		int step;
		j = k / spd;
		if (mode == PLAY_FAST) return smem[k * spd];
		if ((mode == PLAY_HOLD) || (j >= N - 1)) return smem[j];
		// int division truncates toward zero
		step = (int'(smem[j + 1]) - int'(smem[j])) / spd;
		return sample_t'(int'(smem[j]) + (k % spd) * step);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s, got %0h, expected %0h",
				$time, what, got, exp));
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic load_memory();
		int i;
		for (i = 0; i < N; i++) smem[i] = sample_t'($random(seed));
		// extreme neighbours for truncation of large steps
		smem[5] = sample_t'(-32768);
		smem[6] = sample_t'(32767);
		smem[7] = sample_t'(-32768);
		for (i = 0; i < N; i++) begin
			wr_en = 1'b1;
			wr_addr = addr_t'(i);
			wr_data = smem[i];
			tick();
		end
		wr_en = 1'b0;
	endtask

	// quiet outputs before any start, and the frame clock period
	task automatic check_idle();
		int cyc;
		int last_rise;
		logic prev_lrck;
		last_rise = -1;
		prev_lrck = 1'b1;
		for (cyc = 0; cyc < 3 * FRAME; cyc++) begin
			@(negedge clk);
			check_value(32'(frame_active), 0, "frame active before start");
			check_value(32'(finish), 0, "finish before start");
			check_value(32'(dacdat), 0, "serial data before start");
			if (daclrck && !prev_lrck && (last_rise >= 0))
				check_value(cyc - last_rise, FRAME, "frame clock period");
			if (daclrck && !prev_lrck) last_rise = cyc;
			prev_lrck = daclrck;
		end
		if (last_rise < 0)
			abort_run("the frame clock never rose before the first start");
	endtask

	task automatic start_run(input play_mode_e mode, input int spd);
		run_mode = mode;
		run_speed = spd;
		out_idx = 0;
		finish_cnt = 0;
		exp_total = ref_count(mode, spd);
		fin_expect = exp_total;
		tick();
		mode_in = mode;
		speed_in = speed_t'(spd);
		start = 1'b1;
		tick();
		start = 1'b0;
	endtask

	// one finish, then two frames with nothing more
	task automatic wait_finish();
		wait (finish_cnt != 0);
		repeat (2 * FRAME) tick();
		check_value(finish_cnt, 1, "finish strobes per run");
		check_value(out_idx, fin_expect, "outputs per run");
	endtask

	// deserializer and compare against the reference
	always @(negedge clk) begin
		pause_len = pause ? pause_len + 1 : 0;
		if (frame_active) begin
			if (!prev_active && (pause_len > 2))
				abort_run("a frame started while playback was paused");
			cap_word = {cap_word[`AUD_SAMPLE_W-2:0], dacdat};
			cap_bits = cap_bits + 1;
		end else if (prev_active) begin
			check_value(cap_bits, `AUD_SAMPLE_W, "bits per frame");
			if (out_idx >= exp_total)
				abort_run("a frame came after the last expected output");
			check_value(32'(cap_word), 32'(ref_sample(run_mode, run_speed, out_idx)),
				$sformatf("output %0d", out_idx));
			out_idx = out_idx + 1;
			cap_bits = 0;
		end
		prev_active = frame_active;
		if (finish) begin
			finish_cnt = finish_cnt + 1;
			check_value(out_idx, fin_expect, "outputs counted at finish");
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			abort_run("the run timed out before all tests finished");
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		pause = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		mode_in = PLAY_FAST;
		speed_in = speed_t'(1);
		rec_count = count_t'(N);
		seed = 32'h7992_9797;
		cycle_limit = (ref_count(PLAY_FAST, 2) + ref_count(PLAY_FAST, 3) +
			ref_count(PLAY_HOLD, 4) + 2 * ref_count(PLAY_LINEAR, 3) +
			ref_count(PLAY_LINEAR, 8) + ref_count(PLAY_HOLD, 2) +
			ref_count(PLAY_FAST, 1)) * FRAME * 2 + 500;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		load_memory();
		check_idle();
		start_run(PLAY_FAST, 2);
		wait_finish();
		start_run(PLAY_FAST, 3);
		wait_finish();
		start_run(PLAY_HOLD, 4);
		wait_finish();
		start_run(PLAY_LINEAR, 3);
		wait_finish();
		start_run(PLAY_LINEAR, 8);
		wait_finish();
		// pause for four frames right after a frame ends
		start_run(PLAY_LINEAR, 3);
		wait (out_idx == 10);
		tick();
		pause = 1'b1;
		held_idx = out_idx;
		repeat (4 * FRAME) tick();
		check_value(out_idx, held_idx, "outputs while paused");
		pause = 1'b0;
		wait_finish();
		// abort mid-play, then replay the stored samples
		start_run(PLAY_HOLD, 2);
		wait (out_idx == 5);
		tick();
		fin_expect = out_idx;
		stop = 1'b1;
		tick();
		stop = 1'b0;
		wait_finish();
		start_run(PLAY_FAST, 1);
		wait_finish();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: testbench/aud_playback_checker.sv
`timescale 1ns/10ps
`include "aud_config.svh"

module aud_playback_checker (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_daclrck,
	input logic i_dacdat,
	input logic i_frame_active,
	input logic i_finish
);
	logic [7:0] active_len;

	// cycles the frame has been active so far
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			active_len <= '0;
		end else if (i_frame_active) begin
			active_len <= active_len + 8'd1;
		end else begin
			active_len <= '0;
		end
	end

	a_frame_len: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(i_frame_active) |-> (active_len == 8'(`AUD_SAMPLE_W)))
		else $error("frame active ended before one full sample");

	a_frame_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_frame_active |-> (active_len < 8'(`AUD_SAMPLE_W)))
		else $error("frame active lasted longer than one sample");

	// frame starts the clock after the left half begins
	a_frame_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_frame_active) |-> ($past(i_daclrck) && !$past(i_daclrck, 2)))
		else $error("frame active rose away from the frame clock edge");

	a_finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_finish |=> !i_finish)
		else $error("finish high on two cycles in a row");

	a_dacdat_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_frame_active |-> !$isunknown(i_dacdat))
		else $error("serial data unknown inside a frame");

endmodule

// File: source/aud_playback_top.sv
`timescale 1ns/10ps

module aud_playback_top (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_start,
	input  logic                     i_stop,
	input  logic                     i_pause,
	input  aud_ctrl_pkg::play_mode_e i_mode,
	input  aud_types_pkg::speed_t    i_speed,
	input  aud_types_pkg::count_t    i_record_count,
	input  logic                     i_wr_en,
	input  aud_types_pkg::addr_t     i_wr_addr,
	input  aud_types_pkg::sample_t   i_wr_data,
	output logic                     o_daclrck,
	output logic                     o_dacdat,
	output logic                     o_frame_active,
	output logic                     o_finish
);
	import aud_types_pkg::*;

	addr_t   mem_addr;
	sample_t mem_data;
	sample_t play_sample;
	logic    play_en;
	logic    sent;
	logic    lrck_rise;

	aud_sample_mem u_mem (
		.i_clk     (i_clk),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.i_rd_addr (mem_addr),
		.o_rd_data (mem_data)
	);

	aud_lrck_gen u_lrck (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.o_daclrck   (o_daclrck),
		.o_lrck_rise (lrck_rise)
	);

	aud_speed_ctrl u_speed (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_start        (i_start),
		.i_stop         (i_stop),
		.i_pause        (i_pause),
		.i_mode         (i_mode),
		.i_speed        (i_speed),
		.i_record_count (i_record_count),
		.i_mem_data     (mem_data),
		.i_sent         (sent),
		.o_mem_addr     (mem_addr),
		.o_sample       (play_sample),
		.o_play_en      (play_en),
		.o_finish       (o_finish)
	);

	// left channel only
	aud_player u_player (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_play_en      (play_en),
		.i_lrck_rise    (lrck_rise),
		.i_sample       (play_sample),
		.o_dacdat       (o_dacdat),
		.o_frame_active (o_frame_active),
		.o_sent         (sent)
	);

endmodule

// File: source/aud_player.sv
`timescale 1ns/10ps
`include "aud_config.svh"

module aud_player (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_play_en,
	input  logic                   i_lrck_rise,
	input  aud_types_pkg::sample_t i_sample,
	output logic                   o_dacdat,
	output logic                   o_frame_active,
	output logic                   o_sent
);
	import aud_types_pkg::*;
	import aud_ctrl_pkg::*;

	localparam int BIT_W = $clog2(`AUD_SAMPLE_W);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`AUD_SAMPLE_W - 1);

	player_state_e    state;
	logic [BIT_W-1:0] bit_cnt;
	sample_t          shift_r;
	logic             frame_start;

	assign frame_start = (state != PLY_SHIFT) && i_play_en && i_lrck_rise;

	// MSB first, silent outside the frame
	assign o_dacdat = o_frame_active & shift_r[`AUD_SAMPLE_W-1];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= PLY_IDLE;
			bit_cnt <= '0;
			o_frame_active <= 1'b0;
			o_sent <= 1'b0;
		end else begin
			o_sent <= 1'b0;
			case (state)
				PLY_IDLE, PLY_WAIT: begin
					if (frame_start) begin
						state <= PLY_SHIFT;
						bit_cnt <= '0;
						o_frame_active <= 1'b1;
					end else begin
						state <= i_play_en ? PLY_WAIT : PLY_IDLE;
					end
				end
				PLY_SHIFT: begin
					if (bit_cnt == LAST_BIT) begin
						state <= PLY_IDLE;
						o_frame_active <= 1'b0;
						o_sent <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin
					state <= PLY_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (frame_start) begin
			shift_r <= i_sample;
		end else if (state == PLY_SHIFT) begin
			shift_r <= {shift_r[`AUD_SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

// File: source/aud_speed_ctrl.sv
`timescale 1ns/10ps
`include "aud_config.svh"

module aud_speed_ctrl (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_start,
	input  logic                     i_stop,
	input  logic                     i_pause,
	input  aud_ctrl_pkg::play_mode_e i_mode,
	input  aud_types_pkg::speed_t    i_speed,
	input  aud_types_pkg::count_t    i_record_count,
	input  aud_types_pkg::sample_t   i_mem_data,
	input  logic                     i_sent,
	output aud_types_pkg::addr_t     o_mem_addr,
	output aud_types_pkg::sample_t   o_sample,
	output logic                     o_play_en,
	output logic                     o_finish
);
	import aud_types_pkg::*;
	import aud_ctrl_pkg::*;

	localparam int DIFF_W = `AUD_SAMPLE_W + 1;
	localparam int MSB = `AUD_SAMPLE_W - 1;

	speed_state_e state;

	// run settings latched at start
	play_mode_e mode_r;
	speed_t     speed_r;
	count_t     limit_r;

	count_t     out_cnt;
	logic [1:0] fetch_cnt;
	speed_t     interp_cnt;

	// left sample of the current pair
	sample_t    first_r;

	count_t     start_limit;
	logic       slow_mode;
	logic       fetch_last;
	logic       pair_done;
	logic       start_ok;

	logic signed [DIFF_W-1:0] diff;
	logic signed [DIFF_W-1:0] divisor;
	logic signed [DIFF_W-1:0] step_wide;
	sample_t    step;

	assign slow_mode = (mode_r != PLAY_FAST);

	// slow modes need an extra cycle for the second read
	assign fetch_last = slow_mode ? (fetch_cnt == 2'd2) : (fetch_cnt == 2'd1);

	// last interpolation point of this pair
	assign pair_done = ((interp_cnt + speed_t'(1)) == speed_r);

	assign start_ok = i_start && (i_record_count != '0);

	// right sample is on i_mem_data in the last fetch cycle
	assign diff = $signed({i_mem_data[MSB], i_mem_data}) - $signed({first_r[MSB], first_r});
	assign divisor = $signed({{(DIFF_W - `AUD_SPEED_W){1'b0}}, speed_r});
	assign step_wide = diff / divisor;
	// accumulation wraps at 16 bits anyway
	assign step = step_wide[MSB:0];

	// fast: ceil(N / speed), slow: speed * (N - 1) + 1
	always_comb begin
		if (i_mode == PLAY_FAST) begin
			start_limit = (i_record_count + count_t'(i_speed) - count_t'(1)) /
				count_t'(i_speed);
		end else begin
			start_limit = count_t'(i_speed) * (i_record_count - count_t'(1)) + count_t'(1);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= SPD_IDLE;
			mode_r <= PLAY_FAST;
			speed_r <= '0;
			limit_r <= '0;
			out_cnt <= '0;
			fetch_cnt <= '0;
			interp_cnt <= '0;
			o_mem_addr <= '0;
			o_play_en <= 1'b0;
			o_finish <= 1'b0;
		end else begin
			o_finish <= 1'b0;
			if (i_stop) begin
				// abort from any state
				state <= SPD_IDLE;
				o_play_en <= 1'b0;
				o_finish <= 1'b1;
			end else begin
				case (state)
					SPD_IDLE: begin
						if (start_ok) begin
							mode_r <= i_mode;
							speed_r <= i_speed;
							limit_r <= start_limit;
							out_cnt <= '0;
							fetch_cnt <= '0;
							interp_cnt <= '0;
							o_mem_addr <= '0;
							state <= SPD_FETCH;
						end
					end
					SPD_FETCH: begin
						fetch_cnt <= fetch_cnt + 2'd1;
						// point at the right sample of the pair
						if (slow_mode && (fetch_cnt == 2'd0)) begin
							o_mem_addr <= o_mem_addr + addr_t'(1);
						end
						// back to the left one unless the pair is used up
						if (slow_mode && (fetch_cnt == 2'd1) && !pair_done) begin
							o_mem_addr <= o_mem_addr - addr_t'(1);
						end
						if (fetch_last) begin
							fetch_cnt <= '0;
							out_cnt <= out_cnt + count_t'(1);
							o_play_en <= !i_pause;
							state <= SPD_SEND;
							if (slow_mode) begin
								interp_cnt <= pair_done ? '0 : interp_cnt + speed_t'(1);
							end else begin
								o_mem_addr <= o_mem_addr + addr_t'(speed_r);
							end
						end
					end
					SPD_SEND: begin
						// sample stays pending while paused
						o_play_en <= !i_pause;
						if (i_sent) begin
							o_play_en <= 1'b0;
							if (out_cnt == limit_r) begin
								o_finish <= 1'b1;
								state <= SPD_IDLE;
							end else begin
								state <= SPD_FETCH;
							end
						end
					end
					default: begin
						state <= SPD_IDLE;
					end
				endcase
			end
		end
	end

	// sample datapath
	always_ff @(posedge i_clk) begin
		if (state == SPD_FETCH) begin
			if (slow_mode && (fetch_cnt == 2'd1)) begin
				first_r <= i_mem_data;
			end
			if (fetch_last) begin
				if (!slow_mode) begin
					o_sample <= i_mem_data;
				end else if ((mode_r == PLAY_LINEAR) && (interp_cnt != '0)) begin
					o_sample <= o_sample + step;
				end else begin
					// hold, or first point of a linear pair
					o_sample <= first_r;
				end
			end
		end
	end

endmodule

// File: source/aud_lrck_gen.sv
`timescale 1ns/10ps
`include "aud_config.svh"

module aud_lrck_gen (
	input  logic i_clk,
	input  logic i_rst_n,
	output logic o_daclrck,
	output logic o_lrck_rise
);
	localparam int CNT_W = $clog2(`AUD_HALF_FRAME);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`AUD_HALF_FRAME - 1);

	logic [CNT_W-1:0] half_cnt;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			half_cnt <= '0;
			o_daclrck <= 1'b0;
			o_lrck_rise <= 1'b0;
		end else begin
			o_lrck_rise <= 1'b0;
			if (half_cnt == LAST_CNT) begin
				half_cnt <= '0;
				o_daclrck <= ~o_daclrck;
				// flag only the low to high flip, left half starts
				o_lrck_rise <= ~o_daclrck;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

endmodule

// File: source/aud_sample_mem.sv
`timescale 1ns/10ps
`include "aud_config.svh"

module aud_sample_mem (
	input  logic                   i_clk,
	input  logic                   i_wr_en,
	input  aud_types_pkg::addr_t   i_wr_addr,
	input  aud_types_pkg::sample_t i_wr_data,
	input  aud_types_pkg::addr_t   i_rd_addr,
	output aud_types_pkg::sample_t o_rd_data
);
	import aud_types_pkg::*;

	sample_t mem [`AUD_MEM_DEPTH];

	// load port from outside
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// registered read, data one clock after the address
	always_ff @(posedge i_clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: source/aud_ctrl_pkg.sv
package aud_ctrl_pkg;

	typedef enum logic [1:0] {
		PLAY_FAST   = 2'd0,
		PLAY_HOLD   = 2'd1,
		PLAY_LINEAR = 2'd2
	} play_mode_e;

	// speed control FSM
	typedef enum logic [1:0] {
		SPD_IDLE  = 2'd0,
		SPD_FETCH = 2'd1,
		SPD_SEND  = 2'd2
	} speed_state_e;

	// serializer FSM
	typedef enum logic [1:0] {
		PLY_IDLE  = 2'd0,
		PLY_WAIT  = 2'd1,
		PLY_SHIFT = 2'd2
	} player_state_e;

endpackage

// File: source/aud_types_pkg.sv
`include "aud_config.svh"

package aud_types_pkg;

	// signed PCM sample as stored and played
	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

	// sample memory address
	typedef logic [`AUD_ADDR_W-1:0] addr_t;

	// output samples per run
	typedef logic [`AUD_COUNT_W-1:0] count_t;

	// skip, repeat or interpolation factor
	typedef logic [`AUD_SPEED_W-1:0] speed_t;

endpackage

// File: source/aud_config.svh
`ifndef AUD_CONFIG_SVH
`define AUD_CONFIG_SVH

// one stored audio sample
`define AUD_SAMPLE_W 16

// sample memory
`define AUD_ADDR_W 10
`define AUD_MEM_DEPTH 1024

// bit clocks per half of the left/right frame
// must exceed the sample width by at least 4
`define AUD_HALF_FRAME 24

// output-sample counter, covers depth times the largest speed
`define AUD_COUNT_W 24

// speed factor, valid 1 to 8
`define AUD_SPEED_W 4

`endif
